// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_decode_stage
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard hw/*.sv hw/*.svh test/*.sv test/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+hw
+incdir+test
hw/rv_decode_pkg.sv
hw/rv_instr_decoder.sv
hw/rv_gpr_file.sv
hw/rv_operand_unit.sv
hw/rv_issue_register.sv
hw/rv_decode_stage.sv
test/tb_rv_decode_stage.sv

// File: hw/rv_decode_macros.svh
// Data and register widths, RV32I major opcode values

`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// Widths fixed by the ISA
`define XLEN       32
`define ILEN       32
`define GPR_ADDR_W 5
`define GPR_NUM    32

// Major opcodes, instr[6:0]
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

`endif

// File: hw/rv_decode_pkg.sv
// Decode stage enums, control and packet structs, instruction format union

`include "rv_decode_macros.svh"

package rv_decode_pkg;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {RS1_DATA, CURRENT_PC, ZERO} op1_sel_e;

  typedef enum logic [1:0] {RS2_DATA, IMM_I, IMM_U, NEXT_PC} op2_sel_e;

  // Same encoding as funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_BYTE   = 3'b000,
    MEM_HALF   = 3'b001,
    MEM_WORD   = 3'b010,
    MEM_BYTE_U = 3'b100,
    MEM_HALF_U = 3'b101
  } mem_size_e;

  typedef enum logic {ALU_RESULT, LSU_DATA} wb_src_e;

  ////////////////////////////////////////////////
  // Instruction formats

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } instr_s_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_u_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_j_t;

  typedef union packed {
    logic [`ILEN-1:0] raw;
    instr_r_t         r;
    instr_i_t         i;
    instr_s_t         s;
    instr_b_t         b;
    instr_u_t         u;
    instr_j_t         j;
  } instr_u;

  ////////////////////////////////////////////////
  // Stage structs

  typedef struct packed {
    logic      rs1_re;
    logic      rs2_re;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    alu_op_e   alu_op;
    logic      mem_req;
    logic      mem_we;
    mem_size_e mem_size;
    logic      wb_we;
    wb_src_e   wb_src;
    logic      branch;
    logic      jal;
    logic      jalr;
    logic      load;
    logic      illegal;
  } decode_ctrl_t;

  typedef struct packed {
    logic                   en;
    logic [`GPR_ADDR_W-1:0] addr;
    logic [`XLEN-1:0]       data;
  } gpr_wr_t;

  typedef struct packed {
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    alu_op_e                alu_op;
    logic                   mem_req;
    logic                   mem_we;
    mem_size_e              mem_size;
    logic [`XLEN-1:0]       mem_addr;
    logic [`XLEN-1:0]       mem_data;
    logic                   gpr_we;
    logic [`GPR_ADDR_W-1:0] gpr_addr;
    wb_src_e                gpr_src;
    logic                   branch;
    logic                   jal;
    logic                   jalr;
    logic                   illegal;
    logic [`XLEN-1:0]       target_pc;
    logic [`XLEN-1:0]       next_pc;
    logic                   br_j_taken;
  } issue_pkt_t;

  typedef struct packed {
    logic [`GPR_ADDR_W-1:0] rs1_addr;
    logic                   rs1_req;
    logic [`GPR_ADDR_W-1:0] rs2_addr;
    logic                   rs2_req;
  } src_req_t;

endpackage

// File: hw/rv_decode_stage.sv
// Decode stage top: decoder, register file, operand unit, issue register

`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module rv_decode_stage (
  input  logic                      clk_i,
  input  logic                      arstn_i,

  // Fetch
  input  rv_decode_pkg::instr_u     f_instr_i,
  input  logic [`XLEN-1:0]          f_current_pc_i,
  input  logic [`XLEN-1:0]          f_next_pc_i,
  input  logic                      f_valid_i,

  // Control unit
  input  logic                      cu_stall_f_i,
  input  logic                      cu_stall_d_i,
  input  logic                      cu_kill_d_i,

  // Writeback
  input  rv_decode_pkg::gpr_wr_t    m_gpr_wr_i,

  output logic                      d_valid_o,
  output rv_decode_pkg::issue_pkt_t d_issue_o,
  output rv_decode_pkg::src_req_t   d_src_req_o
);

  import rv_decode_pkg::*;

  decode_ctrl_t     ctrl;
  issue_pkt_t       pkt_next;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic             accept;

  rv_instr_decoder i_rv_instr_decoder (
    .instr_i ( f_instr_i ),
    .ctrl_o  ( ctrl      )
  );

  rv_gpr_file i_rv_gpr_file (
    .clk_i      ( clk_i          ),
    .arstn_i    ( arstn_i        ),
    .wr_i       ( m_gpr_wr_i     ),
    .rs1_addr_i ( f_instr_i.r.rs1 ),
    .rs2_addr_i ( f_instr_i.r.rs2 ),
    .rs1_data_o ( rs1_data       ),
    .rs2_data_o ( rs2_data       )
  );

  rv_operand_unit i_rv_operand_unit (
    .instr_i      ( f_instr_i      ),
    .ctrl_i       ( ctrl           ),
    .rs1_data_i   ( rs1_data       ),
    .rs2_data_i   ( rs2_data       ),
    .current_pc_i ( f_current_pc_i ),
    .next_pc_i    ( f_next_pc_i    ),
    .pkt_o        ( pkt_next       )
  );

  ////////////////////////////////////////////////
  // Issue

  assign accept = f_valid_i & ~cu_stall_f_i;

  rv_issue_register i_rv_issue_register (
    .clk_i    ( clk_i        ),
    .arstn_i  ( arstn_i      ),
    .accept_i ( accept       ),
    .stall_i  ( cu_stall_d_i ),
    .kill_i   ( cu_kill_d_i  ),
    .pkt_i    ( pkt_next     ),
    .valid_o  ( d_valid_o    ),
    .pkt_o    ( d_issue_o    )
  );

  // Source registers for the hazard unit, same cycle
  assign d_src_req_o.rs1_addr = f_instr_i.r.rs1;
  assign d_src_req_o.rs1_req  = ctrl.rs1_re;
  assign d_src_req_o.rs2_addr = f_instr_i.r.rs2;
  assign d_src_req_o.rs2_req  = ctrl.rs2_re;

endmodule

// File: hw/rv_gpr_file.sv
// 32-entry general purpose register file, two read ports, one write port

`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module rv_gpr_file (
  input  logic                   clk_i,
  input  logic                   arstn_i,
  input  rv_decode_pkg::gpr_wr_t wr_i,
  input  logic [`GPR_ADDR_W-1:0] rs1_addr_i,
  input  logic [`GPR_ADDR_W-1:0] rs2_addr_i,
  output logic [`XLEN-1:0]       rs1_data_o,
  output logic [`XLEN-1:0]       rs2_data_o
);

  logic [`XLEN-1:0] regs [0:`GPR_NUM-1];

  // x0 is never written
  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      for (int k = 0; k < `GPR_NUM; k++) begin
        regs[k] <= '0;
      end
    end else if (wr_i.en && (wr_i.addr != '0)) begin
      regs[wr_i.addr] <= wr_i.data;
    end
  end

  // No write bypass, new value visible next cycle
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: hw/rv_instr_decoder.sv
// RV32I instruction decoder producing the stage control fields

`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module rv_instr_decoder (
  input  rv_decode_pkg::instr_u       instr_i,
  output rv_decode_pkg::decode_ctrl_t ctrl_o
);

  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;

  // Register-register and register-immediate ALU ops share funct3
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  function automatic alu_op_e branch_op(input logic [2:0] f3);
    alu_op_e op;
    case (f3)
      3'b001:  op = ALU_NE;
      3'b100:  op = ALU_LT;
      3'b101:  op = ALU_GE;
      3'b110:  op = ALU_LTU;
      3'b111:  op = ALU_GEU;
      default: op = ALU_EQ;
    endcase
    return op;
  endfunction

  assign opcode    = instr_i.r.opcode;
  assign funct3    = instr_i.r.funct3;
  assign funct7_b5 = instr_i.r.funct7[5];

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.op1_sel  = RS1_DATA;
    ctrl_o.op2_sel  = RS2_DATA;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.mem_size = mem_size_e'(funct3);
    ctrl_o.wb_src   = ALU_RESULT;

    case (opcode)
      `OPC_LUI: begin
        ctrl_o.op1_sel = ZERO;
        ctrl_o.op2_sel = IMM_U;
        ctrl_o.wb_we   = 1'b1;
      end
      `OPC_AUIPC: begin
        ctrl_o.op1_sel = CURRENT_PC;
        ctrl_o.op2_sel = IMM_U;
        ctrl_o.wb_we   = 1'b1;
      end
      // Link value is 0 + next_pc, added in execute
      `OPC_JAL: begin
        ctrl_o.op1_sel = ZERO;
        ctrl_o.op2_sel = NEXT_PC;
        ctrl_o.wb_we   = 1'b1;
        ctrl_o.jal     = 1'b1;
      end
      `OPC_JALR: begin
        ctrl_o.rs1_re  = 1'b1;
        ctrl_o.op1_sel = ZERO;
        ctrl_o.op2_sel = NEXT_PC;
        ctrl_o.wb_we   = 1'b1;
        ctrl_o.jalr    = 1'b1;
      end
      `OPC_BRANCH: begin
        ctrl_o.rs1_re = 1'b1;
        ctrl_o.rs2_re = 1'b1;
        ctrl_o.alu_op = branch_op(funct3);
        ctrl_o.branch = 1'b1;
      end
      `OPC_LOAD: begin
        ctrl_o.rs1_re  = 1'b1;
        ctrl_o.op2_sel = IMM_I;
        ctrl_o.mem_req = 1'b1;
        ctrl_o.load    = 1'b1;
        ctrl_o.wb_we   = 1'b1;
        ctrl_o.wb_src  = LSU_DATA;
      end
      // Store data leaves through op2
      `OPC_STORE: begin
        ctrl_o.rs1_re  = 1'b1;
        ctrl_o.rs2_re  = 1'b1;
        ctrl_o.mem_req = 1'b1;
        ctrl_o.mem_we  = 1'b1;
      end
      `OPC_OP_IMM: begin
        ctrl_o.rs1_re  = 1'b1;
        ctrl_o.op2_sel = IMM_I;
        ctrl_o.alu_op  = arith_op(funct3, funct7_b5 & (funct3 == 3'b101));
        ctrl_o.wb_we   = 1'b1;
      end
      `OPC_OP: begin
        ctrl_o.rs1_re = 1'b1;
        ctrl_o.rs2_re = 1'b1;
        ctrl_o.alu_op = arith_op(funct3, funct7_b5);
        ctrl_o.wb_we  = 1'b1;
      end
      default: begin
        ctrl_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: hw/rv_issue_register.sv
// One-entry issue register with valid flag, stall hold and kill

`timescale 1ns/1ns

module rv_issue_register (
  input  logic                      clk_i,
  input  logic                      arstn_i,
  input  logic                      accept_i,
  input  logic                      stall_i,
  input  logic                      kill_i,
  input  rv_decode_pkg::issue_pkt_t pkt_i,
  output logic                      valid_o,
  output rv_decode_pkg::issue_pkt_t pkt_o
);

  import rv_decode_pkg::*;

  logic       valid_q;
  issue_pkt_t pkt_q;

  // Kill wins over stall
  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      valid_q <= 1'b0;
    end else if (kill_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= accept_i;
    end
  end

  // Payload only moves on an accepted, unstalled cycle
  always_ff @(posedge clk_i) begin
    if (accept_i && !stall_i) begin
      pkt_q <= pkt_i;
    end
  end

  assign valid_o = valid_q;
  assign pkt_o   = pkt_q;

endmodule

// File: hw/rv_operand_unit.sv
// Immediate generation, operand selection, memory address and data, target PC

`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module rv_operand_unit (
  input  rv_decode_pkg::instr_u       instr_i,
  input  rv_decode_pkg::decode_ctrl_t ctrl_i,
  input  logic [`XLEN-1:0]            rs1_data_i,
  input  logic [`XLEN-1:0]            rs2_data_i,
  input  logic [`XLEN-1:0]            current_pc_i,
  input  logic [`XLEN-1:0]            next_pc_i,
  output rv_decode_pkg::issue_pkt_t   pkt_o
);

  import rv_decode_pkg::*;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [`XLEN-1:0] target_pc;

  ////////////////////////////////////////////////
  // Immediates

  assign imm_i = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
  assign imm_s = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
  assign imm_b = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                  instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
  assign imm_u = {instr_i.u.imm_31_12, 12'b0};
  assign imm_j = {{11{instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                  instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

  ////////////////////////////////////////////////
  // Operands

  always_comb begin
    case (ctrl_i.op1_sel)
      RS1_DATA:   op1 = rs1_data_i;
      CURRENT_PC: op1 = current_pc_i;
      default:    op1 = '0;
    endcase
  end

  always_comb begin
    case (ctrl_i.op2_sel)
      RS2_DATA: op2 = rs2_data_i;
      IMM_I:    op2 = imm_i;
      IMM_U:    op2 = imm_u;
      default:  op2 = next_pc_i;
    endcase
  end

  // JALR target has bit 0 cleared
  always_comb begin
    if (ctrl_i.jalr) begin
      target_pc = (rs1_data_i + imm_i) & ~`XLEN'd1;
    end else if (ctrl_i.jal) begin
      target_pc = current_pc_i + imm_j;
    end else begin
      target_pc = current_pc_i + imm_b;
    end
  end

  always_comb begin
    pkt_o.op1        = op1;
    pkt_o.op2        = op2;
    pkt_o.alu_op     = ctrl_i.alu_op;
    pkt_o.mem_req    = ctrl_i.mem_req;
    pkt_o.mem_we     = ctrl_i.mem_we;
    pkt_o.mem_size   = ctrl_i.mem_size;
    pkt_o.mem_addr   = op1 + (ctrl_i.load ? imm_i : imm_s);
    pkt_o.mem_data   = op2;
    pkt_o.gpr_we     = ctrl_i.wb_we;
    pkt_o.gpr_addr   = instr_i.r.rd;
    pkt_o.gpr_src    = ctrl_i.wb_src;
    pkt_o.branch     = ctrl_i.branch;
    pkt_o.jal        = ctrl_i.jal;
    pkt_o.jalr       = ctrl_i.jalr;
    pkt_o.illegal    = ctrl_i.illegal;
    pkt_o.target_pc  = target_pc;
    pkt_o.next_pc    = next_pc_i;
    pkt_o.br_j_taken = ctrl_i.jal | ctrl_i.jalr;
  end

endmodule

// File: test/tb_rv_decode_model.svh
// Reference immediates, source requests and expected issue packet for the decode stage

`ifndef TB_RV_DECODE_MODEL_SVH
`define TB_RV_DECODE_MODEL_SVH

function automatic logic [31:0] i_imm_of(input logic [31:0] w);
  return {{20{w[31]}}, w[31:20]};
endfunction

function automatic logic [31:0] s_imm_of(input logic [31:0] w);
  return {{20{w[31]}}, w[31:25], w[11:7]};
endfunction

function automatic logic [31:0] b_imm_of(input logic [31:0] w);
  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic logic [31:0] j_imm_of(input logic [31:0] w);
  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
endfunction

// Read flags predicted from the opcode alone
function automatic src_req_t src_req_of(input logic [31:0] w);
  src_req_t s;
  logic [6:0] opc;
  opc = w[6:0];
  s.rs1_addr = w[19:15];
  s.rs2_addr = w[24:20];
  s.rs1_req  = (opc == `OPC_JALR) || (opc == `OPC_BRANCH) || (opc == `OPC_LOAD) ||
               (opc == `OPC_STORE) || (opc == `OPC_OP_IMM) || (opc == `OPC_OP);
  s.rs2_req  = (opc == `OPC_BRANCH) || (opc == `OPC_STORE) || (opc == `OPC_OP);
  return s;
endfunction

function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
  alu_op_e a;
  case (f3)
    3'd0:    a = alt ? ALU_SUB : ALU_ADD;
    3'd1:    a = ALU_SLL;
    3'd2:    a = ALU_SLT;
    3'd3:    a = ALU_SLTU;
    3'd4:    a = ALU_XOR;
    3'd5:    a = alt ? ALU_SRA : ALU_SRL;
    3'd6:    a = ALU_OR;
    default: a = ALU_AND;
  endcase
  return a;
endfunction

function automatic alu_op_e cmp_op_of(input logic [2:0] f3);
  alu_op_e a;
  case (f3)
    3'd1:    a = ALU_NE;
    3'd4:    a = ALU_LT;
    3'd5:    a = ALU_GE;
    3'd6:    a = ALU_LTU;
    3'd7:    a = ALU_GEU;
    default: a = ALU_EQ;
  endcase
  return a;
endfunction

function automatic issue_pkt_t expected_issue(input logic [31:0] w, input logic [31:0] pc,
    input logic [31:0] npc, input logic [31:0] r1, input logic [31:0] r2);
  issue_pkt_t p;
  logic [2:0] f3;
  f3 = w[14:12];
  p = '0;
  p.alu_op   = ALU_ADD;
  p.gpr_src  = ALU_RESULT;
  p.gpr_addr = w[11:7];
  p.next_pc  = npc;
  p.mem_size = mem_size_e'(f3);
  case (w[6:0])
    `OPC_LUI: begin
      p.op2    = {w[31:12], 12'b0};
      p.gpr_we = 1'b1;
    end
    `OPC_AUIPC: begin
      p.op1    = pc;
      p.op2    = {w[31:12], 12'b0};
      p.gpr_we = 1'b1;
    end
    `OPC_JAL: begin
      p.op2        = npc;
      p.gpr_we     = 1'b1;
      p.jal        = 1'b1;
      p.br_j_taken = 1'b1;
      p.target_pc  = pc + j_imm_of(w);
    end
    `OPC_JALR: begin
      p.op2        = npc;
      p.gpr_we     = 1'b1;
      p.jalr       = 1'b1;
      p.br_j_taken = 1'b1;
      p.target_pc  = (r1 + i_imm_of(w)) & 32'hffff_fffe;
    end
    `OPC_BRANCH: begin
      p.op1       = r1;
      p.op2       = r2;
      p.alu_op    = cmp_op_of(f3);
      p.branch    = 1'b1;
      p.target_pc = pc + b_imm_of(w);
    end
    `OPC_LOAD: begin
      p.op1      = r1;
      p.op2      = i_imm_of(w);
      p.mem_req  = 1'b1;
      p.gpr_we   = 1'b1;
      p.gpr_src  = LSU_DATA;
      p.mem_addr = r1 + i_imm_of(w);
    end
    `OPC_STORE: begin
      p.op1      = r1;
      p.op2      = r2;
      p.mem_req  = 1'b1;
      p.mem_we   = 1'b1;
      p.mem_addr = r1 + s_imm_of(w);
    end
    `OPC_OP_IMM: begin
      p.op1    = r1;
      p.op2    = i_imm_of(w);
      p.alu_op = alu_op_of(f3, w[30] && (f3 == 3'd5));
      p.gpr_we = 1'b1;
    end
    `OPC_OP: begin
      p.op1    = r1;
      p.op2    = r2;
      p.alu_op = alu_op_of(f3, w[30]);
      p.gpr_we = 1'b1;
    end
    default: begin
      p.illegal = 1'b1;
    end
  endcase
  p.mem_data = p.op2;
  return p;
endfunction

`endif

// File: test/tb_rv_decode_stage.sv
// Decode stage testbench with clock, reset, LFSR stimulus, timeout and assertions

`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module tb_rv_decode_stage;

  import rv_decode_pkg::*;

  `include "tb_rv_decode_model.svh"

  localparam int N_INSTR     = 400;
  localparam int CYCLE_LIMIT = 2 * (4 + 34 + N_INSTR + 6);

  logic        clk_i;
  logic        arstn_i;
  instr_u      f_instr_i;
  logic [31:0] f_current_pc_i;
  logic [31:0] f_next_pc_i;
  logic        f_valid_i;
  logic        cu_stall_f_i;
  logic        cu_stall_d_i;
  logic        cu_kill_d_i;
  gpr_wr_t     m_gpr_wr_i;
  logic        d_valid_o;
  issue_pkt_t  d_issue_o;
  src_req_t    d_src_req_o;

  logic [31:0] lfsr = 32'h2048_029f;
  logic [31:0] ref_regs [0:31];
  logic        exp_valid;
  logic        exp_loaded;
  issue_pkt_t  exp_pkt;
  int          cycles = 0;

  rv_decode_stage i_rv_decode_stage (
    .clk_i          ( clk_i          ),
    .arstn_i        ( arstn_i        ),
    .f_instr_i      ( f_instr_i      ),
    .f_current_pc_i ( f_current_pc_i ),
    .f_next_pc_i    ( f_next_pc_i    ),
    .f_valid_i      ( f_valid_i      ),
    .cu_stall_f_i   ( cu_stall_f_i   ),
    .cu_stall_d_i   ( cu_stall_d_i   ),
    .cu_kill_d_i    ( cu_kill_d_i    ),
    .m_gpr_wr_i     ( m_gpr_wr_i     ),
    .d_valid_o      ( d_valid_o      ),
    .d_issue_o      ( d_issue_o      ),
    .d_src_req_o    ( d_src_req_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic stop_failed();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error: time %0t %s expected %h actual %h", $time, name, exp, act);
    stop_failed();
  endtask

  // Right-shift Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Random word with an opcode from the kept set or a few illegal ones
  function automatic logic [31:0] make_instr();
    logic [31:0] w;
    logic [31:0] pick;
    logic [6:0]  bad [0:3];
    logic [2:0]  ld_f3 [0:4];
    logic [2:0]  br_f3 [0:5];
    bad   = '{7'h00, 7'h0f, 7'h73, 7'h7f};
    ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    w = rand_bits(32);
    pick = rand_bits(4) % 13;
    case (pick)
      0: w[6:0] = `OPC_LUI;
      1: w[6:0] = `OPC_AUIPC;
      2: w[6:0] = `OPC_JAL;
      3: w[6:0] = `OPC_JALR;
      4: w[6:0] = `OPC_OP_IMM;
      5: w[6:0] = `OPC_OP;
      6: begin
        w[6:0]   = `OPC_BRANCH;
        w[14:12] = br_f3[rand_bits(3) % 6];
      end
      7: begin
        w[6:0]   = `OPC_LOAD;
        w[14:12] = ld_f3[rand_bits(3) % 5];
      end
      8: begin
        w[6:0]   = `OPC_STORE;
        w[14:12] = ld_f3[rand_bits(2) % 3];
      end
      default: w[6:0] = bad[pick - 9];
    endcase
    return w;
  endfunction

  ////////////////////////////////////////////////
  // Reference state updated at the clock edge

  always @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      exp_valid  <= 1'b0;
      exp_loaded <= 1'b0;
      for (int k = 0; k < 32; k++) begin
        ref_regs[k] <= '0;
      end
    end else begin
      if (cu_kill_d_i) begin
        exp_valid <= 1'b0;
      end else if (!cu_stall_d_i) begin
        exp_valid <= f_valid_i && !cu_stall_f_i;
      end
      if (f_valid_i && !cu_stall_f_i && !cu_stall_d_i) begin
        exp_pkt    <= expected_issue(f_instr_i, f_current_pc_i, f_next_pc_i,
                                     ref_regs[f_instr_i.raw[19:15]],
                                     ref_regs[f_instr_i.raw[24:20]]);
        exp_loaded <= 1'b1;
      end
      if (m_gpr_wr_i.en && m_gpr_wr_i.addr != 5'd0) begin
        ref_regs[m_gpr_wr_i.addr] <= m_gpr_wr_i.data;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      stop_failed();
    end
  end

  ////////////////////////////////////////////////
  // Checks sampled mid-cycle

  a_valid: assert property (@(negedge clk_i) disable iff (!arstn_i) d_valid_o == exp_valid)
    else report_mismatch("d_valid_o", 32'(exp_valid), 32'(d_valid_o));
  a_src: assert property (@(negedge clk_i) disable iff (!arstn_i)
    d_src_req_o == src_req_of(f_instr_i))
    else report_mismatch("d_src_req_o", 32'(src_req_of(f_instr_i)), 32'(d_src_req_o));
  a_flags: assert property (@(negedge clk_i) disable iff (!arstn_i) exp_loaded |->
    {d_issue_o.mem_req, d_issue_o.mem_we, d_issue_o.gpr_we, d_issue_o.branch, d_issue_o.jal,
     d_issue_o.jalr, d_issue_o.illegal, d_issue_o.br_j_taken} ==
    {exp_pkt.mem_req, exp_pkt.mem_we, exp_pkt.gpr_we, exp_pkt.branch, exp_pkt.jal,
     exp_pkt.jalr, exp_pkt.illegal, exp_pkt.br_j_taken})
    else report_mismatch("d_issue_o.{mem_req,mem_we,gpr_we,branch,jal,jalr,illegal,br_j_taken}",
      32'({exp_pkt.mem_req, exp_pkt.mem_we, exp_pkt.gpr_we, exp_pkt.branch, exp_pkt.jal,
           exp_pkt.jalr, exp_pkt.illegal, exp_pkt.br_j_taken}),
      32'({d_issue_o.mem_req, d_issue_o.mem_we, d_issue_o.gpr_we, d_issue_o.branch,
           d_issue_o.jal, d_issue_o.jalr, d_issue_o.illegal, d_issue_o.br_j_taken}));
  a_rd: assert property (@(negedge clk_i) disable iff (!arstn_i) exp_loaded |->
    d_issue_o.gpr_addr == exp_pkt.gpr_addr)
    else report_mismatch("d_issue_o.gpr_addr", 32'(exp_pkt.gpr_addr), 32'(d_issue_o.gpr_addr));
  a_npc: assert property (@(negedge clk_i) disable iff (!arstn_i) exp_loaded |->
    d_issue_o.next_pc == exp_pkt.next_pc)
    else report_mismatch("d_issue_o.next_pc", exp_pkt.next_pc, d_issue_o.next_pc);
  a_op1: assert property (@(negedge clk_i) disable iff (!arstn_i)
    exp_loaded && !exp_pkt.illegal |-> d_issue_o.op1 == exp_pkt.op1)
    else report_mismatch("d_issue_o.op1", exp_pkt.op1, d_issue_o.op1);
  a_op2: assert property (@(negedge clk_i) disable iff (!arstn_i)
    exp_loaded && !exp_pkt.illegal |-> d_issue_o.op2 == exp_pkt.op2)
    else report_mismatch("d_issue_o.op2", exp_pkt.op2, d_issue_o.op2);
  a_alu: assert property (@(negedge clk_i) disable iff (!arstn_i)
    exp_loaded && !exp_pkt.illegal |->
    {d_issue_o.alu_op, d_issue_o.gpr_src} == {exp_pkt.alu_op, exp_pkt.gpr_src})
    else report_mismatch("d_issue_o.{alu_op,gpr_src}", 32'({exp_pkt.alu_op, exp_pkt.gpr_src}),
      32'({d_issue_o.alu_op, d_issue_o.gpr_src}));
  a_size: assert property (@(negedge clk_i) disable iff (!arstn_i)
    exp_loaded && exp_pkt.mem_req |-> d_issue_o.mem_size == exp_pkt.mem_size)
    else report_mismatch("d_issue_o.mem_size", 32'(exp_pkt.mem_size), 32'(d_issue_o.mem_size));
  a_addr: assert property (@(negedge clk_i) disable iff (!arstn_i)
    exp_loaded && exp_pkt.mem_req |-> d_issue_o.mem_addr == exp_pkt.mem_addr)
    else report_mismatch("d_issue_o.mem_addr", exp_pkt.mem_addr, d_issue_o.mem_addr);
  a_data: assert property (@(negedge clk_i) disable iff (!arstn_i)
    exp_loaded && exp_pkt.mem_req |-> d_issue_o.mem_data == exp_pkt.mem_data)
    else report_mismatch("d_issue_o.mem_data", exp_pkt.mem_data, d_issue_o.mem_data);
  a_target: assert property (@(negedge clk_i) disable iff (!arstn_i)
    exp_loaded && (exp_pkt.branch || exp_pkt.jal || exp_pkt.jalr) |->
    d_issue_o.target_pc == exp_pkt.target_pc)
    else report_mismatch("d_issue_o.target_pc", exp_pkt.target_pc, d_issue_o.target_pc);

  ////////////////////////////////////////////////
  // Stimulus

  task automatic next_cycle();
    @(posedge clk_i);
    #5;
  endtask

  task automatic idle_inputs();
    f_valid_i    = 1'b0;
    cu_stall_f_i = 1'b0;
    cu_stall_d_i = 1'b0;
    cu_kill_d_i  = 1'b0;
    m_gpr_wr_i   = '0;
  endtask

  initial begin
    logic [31:0] r;
    arstn_i        = 1'b0;
    f_instr_i      = '0;
    f_current_pc_i = '0;
    f_next_pc_i    = '0;
    idle_inputs();
    repeat (4) @(posedge clk_i);
    #5;
    arstn_i = 1'b1;
    next_cycle();

    // Fill every register including x0 with nothing issued
    for (int k = 0; k < 32; k++) begin
      r = rand_bits(32);
      m_gpr_wr_i.en   = 1'b1;
      m_gpr_wr_i.addr = 5'(k);
      m_gpr_wr_i.data = r;
      next_cycle();
    end
    idle_inputs();
    next_cycle();

    for (int n = 0; n < N_INSTR; n++) begin
      f_instr_i      = make_instr();
      r              = rand_bits(32);
      f_current_pc_i = {r[31:2], 2'b00};
      f_next_pc_i    = {r[31:2], 2'b00} + 32'd4;
      r              = rand_bits(3);
      f_valid_i      = (r[2:0] != 3'd0);
      r              = rand_bits(3);
      cu_stall_f_i   = (r[2:0] == 3'd0);
      r              = rand_bits(3);
      cu_stall_d_i   = (r[2:0] == 3'd0);
      r              = rand_bits(4);
      cu_kill_d_i    = (r[3:0] == 4'd0);
      r              = rand_bits(2);
      m_gpr_wr_i.en  = (r[1:0] == 2'd0);
      r              = rand_bits(5);
      m_gpr_wr_i.addr = r[4:0];
      m_gpr_wr_i.data = rand_bits(32);
      next_cycle();
    end
    idle_inputs();
    repeat (3) next_cycle();
    $display("All tests passed");
    $finish;
  end

endmodule
